/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int INSN_WIDTH = 32;
    localparam int REG_INDEX_WIDTH = 5;

    // Instruction field widths.
    localparam int OPCODE_WIDTH = 7;
    localparam int FUNCT3_WIDTH = 3;
    localparam int FUNCT7_WIDTH = 7;

    // Major opcodes in bits 6:0 of the instruction.
    localparam logic [OPCODE_WIDTH-1:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_ALU_REG = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_JAL     = 7'b1101111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_JALR    = 7'b1100111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_LUI     = 7'b0110111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_LOAD    = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_STORE   = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_SYSTEM  = 7'b1110011;

    // One class per major opcode.
    typedef enum logic [3:0] {
        branch,
        alu_imm,
        alu_reg,
        jal,
        jalr,
        lui,
        auipc,
        load,
        store,
        system,
        invalid
    } opcode_class_e;

endpackage

/* design/mem_pkg.sv */
package mem_pkg;

    // Data path word.
    localparam int WORD_WIDTH = 32;

    // Word address into each 64K-word RAM.
    localparam int RAM_ADDRESS_WIDTH = 16;

    // Integer register file.
    localparam int REG_COUNT = 32;

endpackage

/* design/block_ram.sv */
`timescale 1ns/1ps

module block_ram #(
    parameter int word_width = mem_pkg::WORD_WIDTH,
    parameter int address_width = mem_pkg::RAM_ADDRESS_WIDTH
) (
    input  logic                     clock,
    input  logic [address_width-1:0] write_address,
    input  logic [address_width-1:0] read_address,
    input  logic                     write,
    input  logic [word_width-1:0]    write_data,
    output logic [word_width-1:0]    read_data
);

    logic [word_width-1:0] mem [0:(2**address_width)-1];

    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_address] <= write_data;
        end
    end

    // Read-first. A same-address write shows up one read later.
    always_ff @(posedge clock) begin
        read_data <= mem[read_address];
    end

    assert property (@(posedge clock) write |-> !$isunknown({write_address, write_data}));

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic                                   write,
    input  logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] write_address,
    input  logic [mem_pkg::WORD_WIDTH-1:0]         write_data,
    input  logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] read1_address,
    output logic [mem_pkg::WORD_WIDTH-1:0]         read1_data,
    input  logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] read2_address,
    output logic [mem_pkg::WORD_WIDTH-1:0]         read2_data
);

    logic [mem_pkg::WORD_WIDTH-1:0] regs [0:mem_pkg::REG_COUNT-1];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < mem_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write && write_address != '0) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 reads as zero on both ports.
    always_ff @(posedge clock) begin
        read1_data <= (read1_address == '0) ? '0 : regs[read1_address];
        read2_data <= (read2_address == '0) ? '0 : regs[read2_address];
    end

    assert property (@(posedge clock) disable iff (rst)
        write && write_address == '0 |=> regs[0] == '0);

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
    input  logic                                  clock,
    input  logic [rv_isa_pkg::INSN_WIDTH-1:0]     insn,
    output rv_isa_pkg::opcode_class_e             opcode_class,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] rs1,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] rs2,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] rd,
    output logic [rv_isa_pkg::FUNCT3_WIDTH-1:0]   funct3,
    output logic [rv_isa_pkg::FUNCT7_WIDTH-1:0]   funct7,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] shamt,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]     imm_alu_load,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]     imm_store,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]     imm_branch,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]     imm_upper,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]     imm_jump
);

    rv_isa_pkg::opcode_class_e next_class;
    logic [rv_isa_pkg::OPCODE_WIDTH-1:0] opcode;

    assign opcode = insn[rv_isa_pkg::OPCODE_WIDTH-1:0];

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_BRANCH:  next_class = rv_isa_pkg::branch;
            rv_isa_pkg::OPC_ALU_IMM: next_class = rv_isa_pkg::alu_imm;
            rv_isa_pkg::OPC_ALU_REG: next_class = rv_isa_pkg::alu_reg;
            rv_isa_pkg::OPC_JAL:     next_class = rv_isa_pkg::jal;
            rv_isa_pkg::OPC_JALR:    next_class = rv_isa_pkg::jalr;
            rv_isa_pkg::OPC_LUI:     next_class = rv_isa_pkg::lui;
            rv_isa_pkg::OPC_AUIPC:   next_class = rv_isa_pkg::auipc;
            rv_isa_pkg::OPC_LOAD:    next_class = rv_isa_pkg::load;
            rv_isa_pkg::OPC_STORE:   next_class = rv_isa_pkg::store;
            rv_isa_pkg::OPC_SYSTEM:  next_class = rv_isa_pkg::system;
            default:                 next_class = rv_isa_pkg::invalid;
        endcase
    end

    // Every field is decoded for every word regardless of format.
    always_ff @(posedge clock) begin
        opcode_class <= next_class;
        rd <= insn[11:7];
        funct3 <= insn[14:12];
        rs1 <= insn[19:15];
        rs2 <= insn[24:20];
        shamt <= insn[24:20];
        funct7 <= insn[31:25];

        imm_alu_load <= {{20{insn[31]}}, insn[31:20]};
        imm_store <= {{20{insn[31]}}, insn[31:25], insn[11:7]};
        // Branch and jump offsets have bit 0 clear.
        imm_branch <= {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        imm_upper <= {insn[31:12], 12'b0};
        imm_jump <= {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    end

    // A known word always decodes to a known class.
    assert property (@(posedge clock) !$isunknown(insn) |=> !$isunknown(opcode_class));

endmodule

/* design/bringup_sequencer.sv */
`timescale 1ns/1ps

module bringup_sequencer (
    input  logic                                   clock,
    input  logic                                   rst,
    output logic                                   led,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] read_address,
    input  logic [mem_pkg::WORD_WIDTH-1:0]         read_data,
    output logic                                   write,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] write_address,
    output logic [mem_pkg::WORD_WIDTH-1:0]         write_data
);

    typedef enum logic [1:0] {
        read_req,
        read_wait,
        write_req,
        write_wait
    } state_e;

    state_e state;
    logic [2:0] heartbeat;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= read_req;
            write <= 1'b0;
            heartbeat <= '0;
        end else begin
            heartbeat <= heartbeat + 3'd1;
            write <= (state == write_req);
            case (state)
                read_req:   state <= read_wait;
                read_wait:  state <= write_req;
                write_req:  state <= write_wait;
                write_wait: state <= read_req;
                default:    state <= read_req;
            endcase
        end
    end

    // Read data for x1 is valid in write_req.
    always_ff @(posedge clock) begin
        if (state == read_req) begin
            read_address <= rv_isa_pkg::REG_INDEX_WIDTH'(1);
        end
        if (state == write_req) begin
            write_address <= rv_isa_pkg::REG_INDEX_WIDTH'(1);
            write_data <= read_data + mem_pkg::WORD_WIDTH'(1);
        end
    end

    assign led = heartbeat[2];

    assert property (@(posedge clock) disable iff (rst) write == (state == write_wait));

endmodule

/* design/soc_main.sv */
`timescale 1ns/1ps

module soc_main (
    input  logic                                     clock,
    input  logic                                     rst,
    output logic                                     led,

    input  logic [mem_pkg::RAM_ADDRESS_WIDTH-1:0]    inst_ext_address,
    input  logic                                     inst_ext_write,
    input  logic [mem_pkg::WORD_WIDTH-1:0]           inst_ext_in_data,
    output logic [mem_pkg::WORD_WIDTH-1:0]           inst_ext_out_data,

    input  logic [mem_pkg::RAM_ADDRESS_WIDTH-1:0]    data_ext_address,
    input  logic                                     data_ext_write,
    input  logic [mem_pkg::WORD_WIDTH-1:0]           data_ext_in_data,
    output logic [mem_pkg::WORD_WIDTH-1:0]           data_ext_out_data,

    input  logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0]   reg_ext_address,
    output logic [mem_pkg::WORD_WIDTH-1:0]           reg_ext_out_data,

    input  logic [rv_isa_pkg::INSN_WIDTH-1:0]        insn_to_decode,
    output rv_isa_pkg::opcode_class_e                decode_class,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0]   decode_rs1,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0]   decode_rs2,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0]   decode_rd,
    output logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0]   decode_shamt,
    output logic [rv_isa_pkg::FUNCT3_WIDTH-1:0]      decode_funct3,
    output logic [rv_isa_pkg::FUNCT7_WIDTH-1:0]      decode_funct7,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]        decode_imm_alu_load,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]        decode_imm_store,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]        decode_imm_branch,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]        decode_imm_upper,
    output logic [rv_isa_pkg::INSN_WIDTH-1:0]        decode_imm_jump
);

    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] seq_read_address;
    logic [mem_pkg::WORD_WIDTH-1:0]         seq_read_data;
    logic                                   seq_write;
    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] seq_write_address;
    logic [mem_pkg::WORD_WIDTH-1:0]         seq_write_data;

    // Host port shares one address for read and write.
    block_ram #(
        .word_width(mem_pkg::WORD_WIDTH),
        .address_width(mem_pkg::RAM_ADDRESS_WIDTH)
    ) inst_ram (
        .clock(clock),
        .write_address(inst_ext_address),
        .read_address(inst_ext_address),
        .write(inst_ext_write),
        .write_data(inst_ext_in_data),
        .read_data(inst_ext_out_data)
    );

    block_ram #(
        .word_width(mem_pkg::WORD_WIDTH),
        .address_width(mem_pkg::RAM_ADDRESS_WIDTH)
    ) data_ram (
        .clock(clock),
        .write_address(data_ext_address),
        .read_address(data_ext_address),
        .write(data_ext_write),
        .write_data(data_ext_in_data),
        .read_data(data_ext_out_data)
    );

    rv_decode decoder (
        .clock(clock),
        .insn(insn_to_decode),
        .opcode_class(decode_class),
        .rs1(decode_rs1),
        .rs2(decode_rs2),
        .rd(decode_rd),
        .funct3(decode_funct3),
        .funct7(decode_funct7),
        .shamt(decode_shamt),
        .imm_alu_load(decode_imm_alu_load),
        .imm_store(decode_imm_store),
        .imm_branch(decode_imm_branch),
        .imm_upper(decode_imm_upper),
        .imm_jump(decode_imm_jump)
    );

    register_file registers (
        .clock(clock),
        .rst(rst),
        .write(seq_write),
        .write_address(seq_write_address),
        .write_data(seq_write_data),
        .read1_address(reg_ext_address),
        .read1_data(reg_ext_out_data),
        .read2_address(seq_read_address),
        .read2_data(seq_read_data)
    );

    // Self-test owns read port 2 and the write port.
    bringup_sequencer sequencer (
        .clock(clock),
        .rst(rst),
        .led(led),
        .read_address(seq_read_address),
        .read_data(seq_read_data),
        .write(seq_write),
        .write_address(seq_write_address),
        .write_data(seq_write_data)
    );

endmodule

/* testbench/tb_checks.svh */
task automatic check_word(input string name, input logic [mem_pkg::WORD_WIDTH-1:0] actual,
                          input logic [mem_pkg::WORD_WIDTH-1:0] expected);
    if (actual !== expected) begin
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_index(input string name,
                           input logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] actual,
                           input logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] expected);
    if (actual !== expected) begin
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_funct3(input string name,
                            input logic [rv_isa_pkg::FUNCT3_WIDTH-1:0] actual,
                            input logic [rv_isa_pkg::FUNCT3_WIDTH-1:0] expected);
    if (actual !== expected) begin
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_funct7(input string name,
                            input logic [rv_isa_pkg::FUNCT7_WIDTH-1:0] actual,
                            input logic [rv_isa_pkg::FUNCT7_WIDTH-1:0] expected);
    if (actual !== expected) begin
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic check_class(input string name, input rv_isa_pkg::opcode_class_e actual,
                           input rv_isa_pkg::opcode_class_e expected);
    if (actual !== expected) begin
        $display("** Error %s: expected %h (%s), actual %h (%s)", name, expected,
                 expected.name(), actual, actual.name());
        fail_count++;
    end else begin
        pass_count++;
    end
endtask

task automatic report_test(input string name, input int errors_before);
    $display("%-18s finished, %0d errors", name, fail_count - errors_before);
endtask

// Instruction encoders for the RV32I formats.
function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] encode_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] encode_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
endfunction

task automatic decode_case(input logic [31:0] insn, input rv_isa_pkg::opcode_class_e cls,
                           input imm_kind_e kind, input logic [31:0] imm);
    @(posedge clock);
    insn_to_decode <= insn;
    @(posedge clock);
    @(negedge clock);
    check_class("decode_class", decode_class, cls);
    check_index("decode_rs1", decode_rs1, insn[19:15]);
    check_index("decode_rs2", decode_rs2, insn[24:20]);
    check_index("decode_rd", decode_rd, insn[11:7]);
    check_index("decode_shamt", decode_shamt, insn[24:20]);
    check_funct3("decode_funct3", decode_funct3, insn[14:12]);
    check_funct7("decode_funct7", decode_funct7, insn[31:25]);
    case (kind)
        imm_i:   check_word("decode_imm_alu_load", decode_imm_alu_load, imm);
        imm_s:   check_word("decode_imm_store", decode_imm_store, imm);
        imm_b:   check_word("decode_imm_branch", decode_imm_branch, imm);
        imm_u:   check_word("decode_imm_upper", decode_imm_upper, imm);
        imm_j:   check_word("decode_imm_jump", decode_imm_jump, imm);
        default: ;
    endcase
endtask

task automatic test_decode();
    int errors_before;
    logic [31:0] imm;
    errors_before = fail_count;
    imm = 32'hfffff804;
    decode_case(encode_b(imm[12:0], 5'd4, 5'd3, 3'b001), rv_isa_pkg::branch, imm_b, imm);
    imm = 32'hfffffffd;
    decode_case(encode_i(imm[11:0], 5'd6, 3'b000, 5'd5, rv_isa_pkg::OPC_ALU_IMM),
                rv_isa_pkg::alu_imm, imm_i, imm);
    // srai x7, x8, 13
    imm = 32'h0000040d;
    decode_case(encode_i(imm[11:0], 5'd8, 3'b101, 5'd7, rv_isa_pkg::OPC_ALU_IMM),
                rv_isa_pkg::alu_imm, imm_i, imm);
    decode_case({7'b0100000, 5'd11, 5'd10, 3'b000, 5'd9, rv_isa_pkg::OPC_ALU_REG},
                rv_isa_pkg::alu_reg, imm_none, '0);
    imm = 32'hfff8a802;
    decode_case(encode_j(imm[20:0], 5'd1), rv_isa_pkg::jal, imm_j, imm);
    imm = 32'h0000000c;
    decode_case(encode_i(imm[11:0], 5'd1, 3'b000, 5'd0, rv_isa_pkg::OPC_JALR),
                rv_isa_pkg::jalr, imm_i, imm);
    imm = 32'h12345000;
    decode_case({imm[31:12], 5'd10, rv_isa_pkg::OPC_LUI}, rv_isa_pkg::lui, imm_u, imm);
    imm = 32'hfffff000;
    decode_case({imm[31:12], 5'd11, rv_isa_pkg::OPC_AUIPC}, rv_isa_pkg::auipc, imm_u, imm);
    imm = 32'hfffff800;
    decode_case(encode_i(imm[11:0], 5'd13, 3'b010, 5'd12, rv_isa_pkg::OPC_LOAD),
                rv_isa_pkg::load, imm_i, imm);
    imm = 32'h000007ff;
    decode_case(encode_s(imm[11:0], 5'd14, 5'd15, 3'b010), rv_isa_pkg::store, imm_s, imm);
    decode_case(encode_i(12'h000, 5'd0, 3'b000, 5'd0, rv_isa_pkg::OPC_SYSTEM),
                rv_isa_pkg::system, imm_i, '0);
    decode_case(32'h1234567f, rv_isa_pkg::invalid, imm_none, '0);
    report_test("decode", errors_before);
endtask

task automatic test_heartbeat();
    int errors_before;
    errors_before = fail_count;
    @(negedge clock);
    check_bit("led", led, 1'b0);
    for (int n = 1; n <= 32; n++) begin
        @(negedge clock);
        // Top bit of a 3-bit counter.
        check_bit("led", led, n[2]);
    end
    report_test("heartbeat", errors_before);
endtask

task automatic test_inst_ram();
    int errors_before;
    logic [31:0] r;
    logic [31:0] old_word;
    errors_before = fail_count;
    for (int i = 0; i < 16; i++) begin
        r = $random(seed);
        // Low bits keep the addresses distinct.
        ram_addresses[i] = {r[11:0], i[3:0]};
        ram_words[i] = $random(seed);
        @(posedge clock);
        inst_ext_address <= ram_addresses[i];
        inst_ext_in_data <= ram_words[i];
        inst_ext_write <= 1'b1;
    end
    @(posedge clock);
    inst_ext_write <= 1'b0;
    for (int i = 0; i < 16; i++) begin
        @(posedge clock);
        inst_ext_address <= ram_addresses[i];
        @(posedge clock);
        @(negedge clock);
        check_word("inst_ext_out_data", inst_ext_out_data, ram_words[i]);
    end
    old_word = ram_words[0];
    ram_words[0] = ~old_word;
    @(posedge clock);
    inst_ext_address <= ram_addresses[0];
    inst_ext_in_data <= ram_words[0];
    inst_ext_write <= 1'b1;
    @(posedge clock);
    inst_ext_write <= 1'b0;
    @(negedge clock);
    check_word("inst_ext_out_data (old)", inst_ext_out_data, old_word);
    @(negedge clock);
    check_word("inst_ext_out_data (new)", inst_ext_out_data, ram_words[0]);
    report_test("inst_ram", errors_before);
endtask

task automatic test_data_ram();
    int errors_before;
    errors_before = fail_count;
    for (int i = 0; i < 16; i++) begin
        @(posedge clock);
        data_ext_address <= ram_addresses[i];
        data_ext_in_data <= ram_words[i] ^ 32'h0f0ff0f0;
        data_ext_write <= 1'b1;
    end
    @(posedge clock);
    data_ext_write <= 1'b0;
    for (int i = 0; i < 16; i++) begin
        @(posedge clock);
        inst_ext_address <= ram_addresses[i];
        data_ext_address <= ram_addresses[i];
        @(posedge clock);
        @(negedge clock);
        check_word("inst_ext_out_data", inst_ext_out_data, ram_words[i]);
        check_word("data_ext_out_data", data_ext_out_data, ram_words[i] ^ 32'h0f0ff0f0);
    end
    report_test("data_ram", errors_before);
endtask

task automatic test_x1_increment();
    int errors_before;
    logic [31:0] first;
    errors_before = fail_count;
    @(posedge clock);
    reg_ext_address <= 5'd1;
    @(posedge clock);
    @(negedge clock);
    first = reg_ext_out_data;
    repeat (40) @(posedge clock);
    @(negedge clock);
    // One increment every 4 cycles.
    check_word("reg_ext_out_data x1 delta", reg_ext_out_data - first, 32'd10);
    report_test("x1_increment", errors_before);
endtask

task automatic test_idle_registers();
    int errors_before;
    errors_before = fail_count;
    for (int r = 0; r < 32; r++) begin
        if (r != 1) begin
            @(posedge clock);
            reg_ext_address <= r[4:0];
            @(posedge clock);
            @(negedge clock);
            check_word($sformatf("reg_ext_out_data x%0d", r), reg_ext_out_data, '0);
        end
    end
    report_test("idle_registers", errors_before);
endtask

/* testbench/tb_main.sv */
`timescale 1ns/1ps

module tb_main;

    // The tests take about 270 cycles.
    localparam int MAX_CYCLES = 2000;

    typedef enum logic [2:0] {imm_none, imm_i, imm_s, imm_b, imm_u, imm_j} imm_kind_e;

    logic                                   clock;
    logic                                   rst;
    logic                                   led;
    logic [mem_pkg::RAM_ADDRESS_WIDTH-1:0]  inst_ext_address;
    logic                                   inst_ext_write;
    logic [mem_pkg::WORD_WIDTH-1:0]         inst_ext_in_data;
    logic [mem_pkg::WORD_WIDTH-1:0]         inst_ext_out_data;
    logic [mem_pkg::RAM_ADDRESS_WIDTH-1:0]  data_ext_address;
    logic                                   data_ext_write;
    logic [mem_pkg::WORD_WIDTH-1:0]         data_ext_in_data;
    logic [mem_pkg::WORD_WIDTH-1:0]         data_ext_out_data;
    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] reg_ext_address;
    logic [mem_pkg::WORD_WIDTH-1:0]         reg_ext_out_data;
    logic [rv_isa_pkg::INSN_WIDTH-1:0]      insn_to_decode;
    rv_isa_pkg::opcode_class_e              decode_class;
    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] decode_rs1;
    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] decode_rs2;
    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] decode_rd;
    logic [rv_isa_pkg::REG_INDEX_WIDTH-1:0] decode_shamt;
    logic [rv_isa_pkg::FUNCT3_WIDTH-1:0]    decode_funct3;
    logic [rv_isa_pkg::FUNCT7_WIDTH-1:0]    decode_funct7;
    logic [rv_isa_pkg::INSN_WIDTH-1:0]      decode_imm_alu_load;
    logic [rv_isa_pkg::INSN_WIDTH-1:0]      decode_imm_store;
    logic [rv_isa_pkg::INSN_WIDTH-1:0]      decode_imm_branch;
    logic [rv_isa_pkg::INSN_WIDTH-1:0]      decode_imm_upper;
    logic [rv_isa_pkg::INSN_WIDTH-1:0]      decode_imm_jump;

    int pass_count;
    int fail_count;
    int cycles = 0;
    integer seed;
    logic [mem_pkg::RAM_ADDRESS_WIDTH-1:0] ram_addresses [16];
    logic [mem_pkg::WORD_WIDTH-1:0] ram_words [16];

    soc_main uut (.*);

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    `include "tb_checks.svh"

    initial begin
        clock = 1'b0;
        seed = 32'hd710;
        pass_count = 0;
        fail_count = 0;
        rst <= 1'b1;
        inst_ext_address <= '0;
        inst_ext_write <= 1'b0;
        inst_ext_in_data <= '0;
        data_ext_address <= '0;
        data_ext_write <= 1'b0;
        data_ext_in_data <= '0;
        reg_ext_address <= '0;
        insn_to_decode <= '0;
        repeat (3) @(posedge clock);
        rst <= 1'b0;

        // Heartbeat goes first so the counter is still in step with reset.
        test_heartbeat();
        test_inst_ram();
        test_data_ram();
        test_decode();
        test_x1_increment();
        test_idle_registers();

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+testbench
design/rv_isa_pkg.sv
design/mem_pkg.sv
design/block_ram.sv
design/register_file.sv
design/rv_decode.sv
design/bringup_sequencer.sv
design/soc_main.sv
testbench/tb_main.sv

/* run.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module tb_main -o tb_main \
    && ./obj_dir/tb_main > sim.log \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1
